//--- tests/decode_stimulus.txt
# test instr valid we wb_rd wb_data | expected valid opcode funct3 funct7 rs1 rs2 rd rs1_data rs2_data imm
# one line per cycle, all values hex except the test name
rst_read 00208033 1 0 00 00000000 1 33 0 00 01 02 00 00000000 00000000 00000000
rst_read 00418033 1 0 00 00000000 1 33 0 00 03 04 00 00000000 00000000 00000000
rst_read 00628033 1 0 00 00000000 1 33 0 00 05 06 00 00000000 00000000 00000000
rst_read 00838033 1 0 00 00000000 1 33 0 00 07 08 00 00000000 00000000 00000000
rst_read 00a48033 1 0 00 00000000 1 33 0 00 09 0a 00 00000000 00000000 00000000
rst_read 00c58033 1 0 00 00000000 1 33 0 00 0b 0c 00 00000000 00000000 00000000
rst_read 00e68033 1 0 00 00000000 1 33 0 00 0d 0e 00 00000000 00000000 00000000
rst_read 01078033 1 0 00 00000000 1 33 0 00 0f 10 00 00000000 00000000 00000000
rst_read 01288033 1 0 00 00000000 1 33 0 00 11 12 00 00000000 00000000 00000000
rst_read 01498033 1 0 00 00000000 1 33 0 00 13 14 00 00000000 00000000 00000000
rst_read 016a8033 1 0 00 00000000 1 33 0 00 15 16 00 00000000 00000000 00000000
rst_read 018b8033 1 0 00 00000000 1 33 0 00 17 18 00 00000000 00000000 00000000
rst_read 01ac8033 1 0 00 00000000 1 33 0 00 19 1a 00 00000000 00000000 00000000
rst_read 01cd8033 1 0 00 00000000 1 33 0 00 1b 1c 00 00000000 00000000 00000000
rst_read 01ee8033 1 0 00 00000000 1 33 0 00 1d 1e 00 00000000 00000000 00000000
rst_read 01ff8033 1 0 00 00000000 1 33 0 00 1f 1f 00 00000000 00000000 00000000
wr_rd 00000033 1 1 05 12345678 1 33 0 00 00 00 00 00000000 00000000 00000000
wr_rd 00000033 1 1 06 deadbeef 1 33 0 00 00 00 00 00000000 00000000 00000000
wr_rd 006283b3 1 0 00 00000000 1 33 0 00 05 06 07 12345678 deadbeef 00000000
x0_wr 00000033 1 1 00 ffffffff 1 33 0 00 00 00 00 00000000 00000000 00000000
x0_wr 00500033 1 0 00 00000000 1 33 0 00 00 05 00 00000000 12345678 00000000
bypass 006400b3 1 1 08 cafef00d 1 33 0 00 08 06 01 cafef00d deadbeef 00000000
bypass 00800033 1 0 00 00000000 1 33 0 00 00 08 00 00000000 cafef00d 00000000
imm_fmt fff28513 1 0 00 00000000 1 13 0 7f 05 1f 0a 12345678 00000000 ffffffff
imm_fmt 00832583 1 0 00 00000000 1 03 2 00 06 08 0b deadbeef cafef00d 00000008
imm_fmt fe62ae23 1 0 00 00000000 1 23 2 7f 05 06 1c 12345678 deadbeef fffffffc
imm_fmt fe628ce3 1 0 00 00000000 1 63 0 7f 05 06 19 12345678 deadbeef fffffff8
imm_fmt 80001637 1 0 00 00000000 1 37 1 40 00 00 0c 00000000 00000000 80001000
imm_fmt ff1ff0ef 1 0 00 00000000 1 6f 7 7f 1f 11 01 00000000 00000000 fffffff0
pipe 006283b3 1 0 00 00000000 1 33 0 00 05 06 07 12345678 deadbeef 00000000
pipe fff28513 0 0 00 00000000 0 13 0 7f 05 1f 0a 12345678 00000000 ffffffff
pipe 00800033 1 0 00 00000000 1 33 0 00 00 08 00 00000000 cafef00d 00000000

//--- verilog.f
+incdir+hw
hw/riscv_pkg.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/decode_stage.sv
tests/decode_stage_tb.sv

//--- Makefile
# Verilator flow for the decode stage

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
RTL_TOP   ?= decode_stage
FILE_LIST ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

RTL_SRCS = hw/riscv_pkg.sv hw/instr_decode.sv hw/reg_file.sv hw/decode_stage.sv
TB_SRCS  = tests/decode_stage_tb.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+hw --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST) $(RTL_SRCS) $(TB_SRCS) hw/riscv_defs.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ns

`include "riscv_defs.svh"

module decode_stage_tb
    import riscv_pkg::*;
();

    localparam int PERIOD    = 40;
    localparam int MAX_LINES = 64;

    // One stimulus line, every column widened to a word
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] valid;
        logic [31:0] we;
        logic [31:0] wr_rd;
        logic [31:0] wr_data;
        logic [31:0] x_valid;
        logic [31:0] x_opcode;
        logic [31:0] x_funct3;
        logic [31:0] x_funct7;
        logic [31:0] x_rs1;
        logic [31:0] x_rs2;
        logic [31:0] x_rd;
        logic [31:0] x_rs1_data;
        logic [31:0] x_rs2_data;
        logic [31:0] x_imm;
    } vec_t;

    logic   clk;
    logic   rst_n;
    instr_u instr;
    logic   instr_valid;
    wb_t    wb;
    id_ex_t id_ex;

    vec_t  vecs [0:MAX_LINES-1];
    string names [0:MAX_LINES-1];
    int    n_lines = 0;
    logic  loaded = 1'b0;
    logic  ok;

    // Totals and per-test counters
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_checks = 0;
    int test_errors = 0;

    decode_stage dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Lines that do not scan as 16 columns are comments
    task automatic load_stimulus(output logic good);
        int               fd;
        int               cnt;
        logic [8*128-1:0] line;
        logic [127:0]     name;
        vec_t             v;
        good = 1'b0;
        fd = $fopen("tests/decode_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, v.instr, v.valid, v.we, v.wr_rd, v.wr_data, v.x_valid,
                        v.x_opcode, v.x_funct3, v.x_funct7, v.x_rs1, v.x_rs2, v.x_rd,
                        v.x_rs1_data, v.x_rs2_data, v.x_imm);
                    if ((cnt == 16) && (n_lines < MAX_LINES)) begin
                        names[n_lines] = $sformatf("%0s", name);
                        vecs[n_lines] = v;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            good = (n_lines > 0);
        end
    endtask

    task automatic apply_vector(input int k);
        instr.raw   = vecs[k].instr;
        instr_valid = vecs[k].valid[0];
        wb.we       = vecs[k].we[0];
        wb.rd       = vecs[k].wr_rd[`REG_ADDR_W-1:0];
        wb.data     = vecs[k].wr_data;
    endtask

    // Quiet bus, x0 reads and no write
    task automatic idle_inputs();
        instr.raw   = '0;
        instr_valid = 1'b0;
        wb          = '0;
    endtask

    task automatic check_value(input string tname, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        test_checks++;
        a_match: assert (actual === expected) else begin
            $display("error %0s %0s expected %h actual %h", tname, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // Whole ID/EX bundle against one line's expected columns
    task automatic check_bundle(input int k);
        check_value(names[k], "valid", vecs[k].x_valid, 32'(id_ex.valid));
        check_value(names[k], "opcode", vecs[k].x_opcode, 32'(id_ex.opcode));
        check_value(names[k], "funct3", vecs[k].x_funct3, 32'(id_ex.funct3));
        check_value(names[k], "funct7", vecs[k].x_funct7, 32'(id_ex.funct7));
        check_value(names[k], "rs1", vecs[k].x_rs1, 32'(id_ex.rs1));
        check_value(names[k], "rs2", vecs[k].x_rs2, 32'(id_ex.rs2));
        check_value(names[k], "rd", vecs[k].x_rd, 32'(id_ex.rd));
        check_value(names[k], "rs1_data", vecs[k].x_rs1_data, id_ex.rs1_data);
        check_value(names[k], "rs2_data", vecs[k].x_rs2_data, id_ex.rs2_data);
        check_value(names[k], "imm", vecs[k].x_imm, id_ex.imm);
    endtask

    task automatic finish_test(input string tname);
        tests++;
        if (test_errors == 0) begin
            $display("test %0s done, %0d checks passed", tname, test_checks);
        end else begin
            $display("test %0s done, %0d of %0d checks failed", tname, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        rst_n = 1'b0;
        idle_inputs();
        load_stimulus(ok);
        loaded = 1'b1;
        if (ok) begin
            repeat (8) @(negedge clk);
            rst_n = 1'b1;
            // Bundle still cleared before the first load
            check_value("reset", "valid", 32'd0, 32'(id_ex.valid));
            check_value("reset", "nonzero_bundle", 32'd0, 32'(id_ex != '0));
            finish_test("reset");
            apply_vector(0);
            // Line k-1 shows up one rising edge after it was driven
            for (int k = 1; k <= n_lines; k++) begin
                @(negedge clk);
                check_bundle(k - 1);
                if ((k == n_lines) || (names[k] != names[k - 1])) begin
                    finish_test(names[k - 1]);
                end
                if (k < n_lines) begin
                    apply_vector(k);
                end else begin
                    idle_inputs();
                end
            end
        end else begin
            $display("stimulus file missing or holds no usable lines");
            errors++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Budget is the line count plus reset and drain margin
    initial begin
        wait (loaded == 1'b1);
        #((n_lines + 20) * PERIOD);
        $display("simulation timed out before all stimulus lines were checked");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns

`include "riscv_defs.svh"

module decode_stage
    import riscv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    // Instruction from fetch
    input  instr_u instr,
    input  logic   instr_valid,

    // Writeback port
    input  wb_t    wb,

    // Registered bundle to execute
    output id_ex_t id_ex
);

    // Decoder outputs
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm;

    // Operand values
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    // Next ID/EX contents
    id_ex_t id_ex_d;

    instr_decode u_instr_decode (
        .instr  (instr),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .imm    (imm)
    );

    // Read addresses come straight from the decoder
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        id_ex_d.valid    = instr_valid;
        id_ex_d.opcode   = opcode;
        id_ex_d.funct3   = funct3;
        id_ex_d.funct7   = funct7;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = rd;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
    end

    // Loads every cycle, no stall path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    // No bundle escapes a reset cycle
    a_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !id_ex.valid)
        else $error("id_ex.valid high right after reset");

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

`include "riscv_defs.svh"

module reg_file
    import riscv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Read addresses
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,

    // Write port
    input  wb_t                    wb,

    // Read data, combinational
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    // Storage for x1..x31 only
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    // Full read view, x0 tied to zero
    logic [`XLEN-1:0] rd_view [0:`REG_COUNT-1];

    // One-hot write enables
    logic [`REG_COUNT-1:1] wr_en;

    // Bypass a same-cycle write, never for x0
    function automatic logic [`XLEN-1:0] bypass_read(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       stored,
        input wb_t                    w
    );
        if (w.we && (w.rd == addr) && (addr != '0)) begin
            return w.data;
        end
        return stored;
    endfunction

    // Address decode gated by the strobe
    always_comb begin
        for (int i = 1; i < `REG_COUNT; i++) begin
            wr_en[i] = wb.we && (wb.rd == i[`REG_ADDR_W-1:0]);
        end
    end

    // One register per entry, cleared on reset
    for (genvar g = 1; g < `REG_COUNT; g++) begin : g_reg
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                regs[g] <= '0;
            end else if (wr_en[g]) begin
                regs[g] <= wb.data;
            end
        end
    end

    always_comb begin
        rd_view[0] = '0;
        for (int i = 1; i < `REG_COUNT; i++) begin
            rd_view[i] = regs[i];
        end
    end

    // Two independent read muxes
    always_comb begin
        rs1_data = bypass_read(rs1_addr, rd_view[rs1_addr], wb);
        rs2_data = bypass_read(rs2_addr, rd_view[rs2_addr], wb);
    end

    // x0 reads as zero, even while x0 is written
    a_x0_zero: assert property (@(posedge clk)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)))
        else $error("x0 read returned nonzero data");

    // Committed write lands one cycle later
    a_write_commit: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.we && (wb.rd != '0)) |=> (rd_view[$past(wb.rd)] == $past(wb.data)))
        else $error("write to x%0d not committed", $past(wb.rd));

    a_read_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({rs1_data, rs2_data}))
        else $error("unknown value on a read port");

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ns

`include "riscv_defs.svh"

module instr_decode
    import riscv_pkg::*;
(
    input  instr_u                 instr,

    // Register addresses
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,

    // Raw control fields
    output logic [6:0]             opcode,
    output logic [2:0]             funct3,
    output logic [6:0]             funct7,

    // Sign-extended immediate
    output logic [`XLEN-1:0]       imm
);

    // Candidate immediates, one per format
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // Register and control fields sit at fixed positions
    // in every format, so the R view covers them all
    always_comb begin
        opcode = instr.r.opcode;
        rd     = instr.r.rd;
        funct3 = instr.r.funct3;
        rs1    = instr.r.rs1;
        rs2    = instr.r.rs2;
        funct7 = instr.r.funct7;
    end

    always_comb begin
        // I-type, 12-bit signed
        imm_i = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};

        // S-type, halves joined around rs2
        imm_s = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

        // B-type, shuffled S bits, halfword aligned
        imm_b = {{(`XLEN-13){instr.s.imm_hi[6]}},
                 instr.s.imm_hi[6],
                 instr.s.imm_lo[0],
                 instr.s.imm_hi[5:0],
                 instr.s.imm_lo[4:1],
                 1'b0};

        // U-type, upper 20 bits
        imm_u = {instr.raw[31:12], 12'b0};

        // J-type, sign in bit 31, then imm[19:12], imm[11], imm[10:1]
        imm_j = {{(`XLEN-21){instr.raw[31]}},
                 instr.raw[31],
                 instr.raw[19:12],
                 instr.raw[20],
                 instr.raw[30:21],
                 1'b0};
    end

    // Format select by opcode
    always_comb begin
        unique case (instr.r.opcode)
            OP_IMM,
            LOAD,
            JALR:    imm = imm_i;
            STORE:   imm = imm_s;
            BRANCH:  imm = imm_b;
            LUI,
            AUIPC:   imm = imm_u;
            JAL:     imm = imm_j;
            // R-type has no immediate
            default: imm = '0;
        endcase

        // Control transfer targets must stay halfword aligned
        if ((instr.r.opcode == BRANCH) || (instr.r.opcode == JAL)) begin
            a_imm_align: assert (imm[0] == 1'b0)
                else $error("odd branch/jump immediate %h", imm);
        end
    end

endmodule

//--- hw/riscv_pkg.sv
`include "riscv_defs.svh"

package riscv_pkg;

    // R-format view, register to register ops
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    // I-format view, also used for JALR and loads
    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // S-format view, immediate split around rs2/rs1
    // B-format reuses the same bit positions
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    // One instruction word, several decodings of the same bits
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
    } instr_u;

    // Writeback port driven from outside the stage
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    // Decoded bundle handed to execute
    typedef struct packed {
        logic                   valid;
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
    } id_ex_t;

    // RV32I major opcodes
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;

endpackage

//--- hw/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// RV32I base integer widths
// Fixed by the instruction encoding, not tunable

// Integer register and data path width
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Width of the rs1, rs2 and rd instruction fields
`define REG_ADDR_W 5

`endif
